// ==== list.f ====
verilog/decodePkg.sv
verilog/decodeCtrlIf.sv
verilog/controlDecoder.sv
verilog/hazardUnit.sv
verilog/registerFile.sv
verilog/issueRegister.sv
verilog/decodeStage.sv
tb/decodeStageTb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - files:
      - verilog/decodePkg.sv
      - verilog/decodeCtrlIf.sv
      - verilog/controlDecoder.sv
      - verilog/hazardUnit.sv
      - verilog/registerFile.sv
      - verilog/issueRegister.sv
      - verilog/decodeStage.sv
  - target: test
    files:
      - tb/decodeStageTb.sv

// ==== tb/decodeStageTb.sv ====
// Checks sample at the falling edge; operand B is Rm unforwarded, operand D follows rd forwarding
`timescale 1ns/10ps

module decodeStageTb import decodePkg::*; ();

  localparam int clkPeriod = 100;
  localparam int driveDelay = 10;
  localparam int maxCycles = 400; // Roughly four times the full run
  localparam logic [3:0] dpCodes [12] = '{dpAnd, dpEor, dpSub, dpRsb, dpAdd, dpAdc,
                                         dpSbc, dpRsc, dpOrr, dpMov, dpBic, dpMvn};

  typedef struct packed {
    logic valid;
    aluOpT aluOp;
    addrModeT addrMode;
    logic setFlags;
    logic load;
    logic rfEnable;
    logic memSize;
    logic memWrite;
    logic memEnable;
  } ctrlRecT;

  logic Clk;
  logic reset;
  logic [31:0] instr;
  logic instrValid;
  logic [3:0] exRd;
  logic exRfEnable;
  logic exLoad;
  logic [31:0] exResult;
  logic [3:0] memRd;
  logic memRfEnable;
  logic [31:0] memResult;
  logic [3:0] wbRd;
  logic wbWrite;
  logic [31:0] wbData;
  logic stall;
  logic issueValid;
  aluOpT issueAluOp;
  addrModeT issueAddrMode;
  logic issueSetFlags;
  logic issueLoad;
  logic issueRfEnable;
  logic issueMemSize;
  logic issueMemWrite;
  logic issueMemEnable;
  logic [31:0] issueOpA;
  logic [31:0] issueOpB;
  logic [31:0] issueOpD;
  logic [3:0] issueRd;
  logic [11:0] issueImm12;

  // Expected record, set with the stimulus and moved one stage at each rising edge
  ctrlRecT nextCtrl;
  ctrlRecT curCtrl;
  ctrlRecT actCtrl;
  logic nextArmCtrl;
  logic curArmCtrl;
  logic nextArmOps;
  logic curArmOps;
  logic [31:0] nextOpA;
  logic [31:0] nextOpB;
  logic [31:0] nextOpD;
  logic [3:0] nextRd;
  logic [11:0] nextImm;
  logic [31:0] curOpA;
  logic [31:0] curOpB;
  logic [31:0] curOpD;
  logic [3:0] curRd;
  logic [11:0] curImm;
  logic armStall; // Stall is checked in the cycle of the stimulus
  logic expStall;

  integer seed;
  int errorCount;
  int testStartErrors;
  int testCount;
  int testFails;
  int cycleCount;
  string testName;
  logic [31:0] shadowRegs [16];

  decodeStage u_decodeStage (
    .Clk(Clk), .reset(reset), .instr(instr), .instrValid(instrValid),
    .exRd(exRd), .exRfEnable(exRfEnable), .exLoad(exLoad), .exResult(exResult),
    .memRd(memRd), .memRfEnable(memRfEnable), .memResult(memResult),
    .wbRd(wbRd), .wbWrite(wbWrite), .wbData(wbData),
    .stall(stall), .issueValid(issueValid), .issueAluOp(issueAluOp),
    .issueAddrMode(issueAddrMode), .issueSetFlags(issueSetFlags), .issueLoad(issueLoad),
    .issueRfEnable(issueRfEnable), .issueMemSize(issueMemSize),
    .issueMemWrite(issueMemWrite), .issueMemEnable(issueMemEnable),
    .issueOpA(issueOpA), .issueOpB(issueOpB), .issueOpD(issueOpD),
    .issueRd(issueRd), .issueImm12(issueImm12)
  );

  assign actCtrl = {issueValid, issueAluOp, issueAddrMode, issueSetFlags, issueLoad,
                    issueRfEnable, issueMemSize, issueMemWrite, issueMemEnable};

  initial begin
    Clk = 1'b0;
    forever #(clkPeriod / 2) Clk = ~Clk;
  end

  always @(posedge Clk) begin
    curCtrl <= nextCtrl;
    curArmCtrl <= nextArmCtrl;
    curArmOps <= nextArmOps;
    curOpA <= nextOpA;
    curOpB <= nextOpB;
    curOpD <= nextOpD;
    curRd <= nextRd;
    curImm <= nextImm;
  end

  always @(posedge Clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= maxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", maxCycles);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic reportMismatch(input string field, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    errorCount++;
    $display("Fail %s %s: expected %h, actual %h", testName, field, expVal, actVal);
  endtask

  checkCtrl: assert property (@(negedge Clk) disable iff (reset)
    curArmCtrl |-> (actCtrl == curCtrl))
    else reportMismatch("controls", curCtrl, actCtrl);
  checkOpA: assert property (@(negedge Clk) disable iff (reset)
    curArmOps |-> (issueOpA == curOpA))
    else reportMismatch("issueOpA", curOpA, issueOpA);
  checkOpB: assert property (@(negedge Clk) disable iff (reset)
    curArmOps |-> (issueOpB == curOpB))
    else reportMismatch("issueOpB", curOpB, issueOpB);
  checkOpD: assert property (@(negedge Clk) disable iff (reset)
    curArmOps |-> (issueOpD == curOpD))
    else reportMismatch("issueOpD", curOpD, issueOpD);
  checkRd: assert property (@(negedge Clk) disable iff (reset)
    curArmOps |-> (issueRd == curRd))
    else reportMismatch("issueRd", curRd, issueRd);
  checkImm: assert property (@(negedge Clk) disable iff (reset)
    curArmOps |-> (issueImm12 == curImm))
    else reportMismatch("issueImm12", curImm, issueImm12);
  checkStall: assert property (@(negedge Clk) disable iff (reset)
    armStall |-> (stall == expStall))
    else reportMismatch("stall", expStall, stall);

  function automatic aluOpT aluForOpcode(input logic [3:0] opcode);
    case (opcode)
      dpAnd: return opAnd;
      dpEor: return opEor;
      dpSub: return opSub;
      dpRsb: return opRsb;
      dpAdd: return opAdd;
      dpAdc: return opAdc;
      dpSbc: return opSbc;
      dpRsc: return opRsc;
      dpOrr: return opOrr;
      dpMov: return opMov;
      dpBic: return opBic;
      dpMvn: return opMvn;
      default: return opPassA;
    endcase
  endfunction

  function automatic ctrlRecT noopCtrl(input logic valid);
    ctrlRecT rec;
    rec = '0;
    rec.valid = valid;
    rec.aluOp = opPassA;
    rec.addrMode = amReg;
    return rec;
  endfunction

  // Wait for the drive point and drop every strobe and check
  task automatic nextCycle();
    @(posedge Clk);
    #driveDelay;
    instrValid = 1'b0;
    exLoad = 1'b0;
    exRfEnable = 1'b0;
    memRfEnable = 1'b0;
    wbWrite = 1'b0;
    nextArmCtrl = 1'b0;
    nextArmOps = 1'b0;
    armStall = 1'b0;
    expStall = 1'b0;
  endtask

  task automatic startTest(input string name);
    testName = name;
    testStartErrors = errorCount;
  endtask

  task automatic finishTest();
    nextCycle();
    @(negedge Clk);
    #1;
    testCount++;
    if (errorCount == testStartErrors) begin
      $display("Test %s: ok", testName);
    end else begin
      testFails++;
      $display("Test %s: failed, %0d mismatches", testName, errorCount - testStartErrors);
    end
  endtask

  task automatic issueDp(input logic [3:0] opcode, input instrClassT cls, input logic sBit);
    nextCycle();
    instr = {4'hE, cls, opcode, sBit, 4'($random(seed)), 4'($random(seed)),
             12'($random(seed))};
    instrValid = 1'b1;
    nextCtrl = noopCtrl(1'b1);
    nextCtrl.aluOp = aluForOpcode(opcode);
    nextCtrl.addrMode = (cls == clsDpImm) ? amRotImm : amShiftReg;
    nextCtrl.setFlags = sBit;
    nextCtrl.rfEnable = 1'b1;
    nextArmCtrl = 1'b1;
  endtask

  task automatic issueLs(input instrClassT cls, input logic u, input logic l, input logic b);
    nextCycle();
    instr = {4'hE, cls, 1'b1, u, b, 1'b0, l, 4'($random(seed)), 4'($random(seed)),
             12'($random(seed))};
    instrValid = 1'b1;
    nextCtrl = noopCtrl(1'b1);
    nextCtrl.aluOp = u ? opAdd : opSub;
    nextCtrl.addrMode = (cls == clsLsImm) ? amImm12 : amShiftReg;
    nextCtrl.load = l;
    nextCtrl.memWrite = ~l;
    nextCtrl.memSize = b;
    nextCtrl.memEnable = 1'b1;
    nextCtrl.rfEnable = 1'b1;
    nextArmCtrl = 1'b1;
  endtask

  task automatic writeReg(input logic [3:0] addr, input logic [31:0] value);
    nextCycle();
    wbWrite = 1'b1;
    wbRd = addr;
    wbData = value;
    shadowRegs[addr] = value;
  endtask

  task automatic readRegs(input logic [3:0] a, input logic [3:0] b, input logic [3:0] d);
    logic [7:0] shiftField;
    shiftField = 8'($random(seed));
    nextCycle();
    instr = {4'hE, clsDpShift, dpAdd, 1'b0, a, d, shiftField, b};
    instrValid = 1'b1;
    nextOpA = shadowRegs[a];
    nextOpB = shadowRegs[b];
    nextOpD = shadowRegs[d];
    nextRd = d;
    nextImm = {shiftField, b};
    nextArmOps = 1'b1;
  endtask

  task automatic forwardCase(input logic onD, input logic exOn, input logic memOn,
                             input logic wbOn);
    logic [3:0] tgt;
    logic [3:0] other;
    logic [3:0] rm;
    logic [31:0] fwdVal;
    nextCycle();
    tgt = 4'($random(seed));
    other = tgt + 4'd5;
    rm = tgt + 4'd9;
    exRd = tgt;
    memRd = tgt;
    wbRd = tgt;
    exResult = $random(seed);
    memResult = $random(seed);
    wbData = $random(seed);
    exRfEnable = exOn;
    memRfEnable = memOn;
    wbWrite = wbOn;
    // Youngest producer wins
    if (exOn) fwdVal = exResult;
    else if (memOn) fwdVal = memResult;
    else if (wbOn) fwdVal = wbData;
    else fwdVal = shadowRegs[tgt];
    if (onD) begin
      instr = {4'hE, clsDpShift, dpOrr, 1'b0, other, tgt, 8'h00, rm};
      nextOpA = shadowRegs[other];
      nextOpD = fwdVal;
      nextRd = tgt;
    end else begin
      instr = {4'hE, clsDpShift, dpOrr, 1'b0, tgt, other, 8'h00, rm};
      nextOpA = fwdVal;
      nextOpD = shadowRegs[other];
      nextRd = other;
    end
    nextOpB = shadowRegs[rm]; // Rm read straight from the file
    nextImm = {8'h00, rm};
    instrValid = 1'b1;
    nextArmOps = 1'b1;
    if (wbOn) shadowRegs[tgt] = wbData;
  endtask

  task automatic loadUseCase(input logic loadInEx, input logic [3:0] ldRd,
                             input logic expectStall);
    nextCycle();
    instr = {4'hE, clsDpShift, dpSub, 1'b1, 4'd3, 4'd4, 12'h005};
    instrValid = 1'b1;
    exLoad = loadInEx;
    exRfEnable = loadInEx;
    exRd = ldRd;
    armStall = 1'b1;
    expStall = expectStall;
    if (expectStall) begin
      nextCtrl = noopCtrl(1'b0); // Bubble
    end else begin
      nextCtrl = noopCtrl(1'b1);
      nextCtrl.aluOp = opSub;
      nextCtrl.addrMode = amShiftReg;
      nextCtrl.setFlags = 1'b1;
      nextCtrl.rfEnable = 1'b1;
    end
    nextArmCtrl = 1'b1;
  endtask

  task automatic idleCycle();
    nextCycle();
    instr = {4'hE, clsDpImm, dpAdd, 1'b1, 20'($random(seed))};
    nextCtrl = noopCtrl(1'b0);
    nextArmCtrl = 1'b1;
  endtask

  task automatic noopWord(input logic [31:0] word);
    nextCycle();
    instr = word;
    instrValid = 1'b1;
    nextCtrl = noopCtrl(1'b1);
    nextArmCtrl = 1'b1;
  endtask

  initial begin
    seed = 32'h67f2_3d46;
    errorCount = 0;
    testCount = 0;
    testFails = 0;
    cycleCount = 0;
    reset = 1'b1;
    instr = '0;
    instrValid = 1'b0;
    exRd = '0;
    exRfEnable = 1'b0;
    exLoad = 1'b0;
    exResult = '0;
    memRd = '0;
    memRfEnable = 1'b0;
    memResult = '0;
    wbRd = '0;
    wbWrite = 1'b0;
    wbData = '0;
    nextCtrl = '0;
    nextArmCtrl = 1'b0;
    nextArmOps = 1'b0;
    nextOpA = '0;
    nextOpB = '0;
    nextOpD = '0;
    nextRd = '0;
    nextImm = '0;
    armStall = 1'b0;
    expStall = 1'b0;

    // Arm during the last reset cycle so the reset state itself is checked
    repeat (4) @(posedge Clk);
    #driveDelay;
    startTest("reset");
    nextCtrl = noopCtrl(1'b0);
    nextArmCtrl = 1'b1;
    @(posedge Clk);
    #driveDelay;
    reset = 1'b0;
    finishTest();

    startTest("dpDecode");
    for (int i = 0; i < 12; i++) begin
      issueDp(dpCodes[i], clsDpShift, 1'($random(seed)));
      issueDp(dpCodes[i], clsDpImm, 1'($random(seed)));
    end
    finishTest();

    startTest("lsDecode");
    for (int i = 0; i < 16; i++) begin
      issueLs(i[3] ? clsLsReg : clsLsImm, i[0], i[1], i[2]);
    end
    finishTest();

    startTest("roundTrip");
    for (int r = 0; r < 16; r++) begin
      writeReg(4'(r), $random(seed));
    end
    repeat (8) readRegs(4'($random(seed)), 4'($random(seed)), 4'($random(seed)));
    finishTest();

    startTest("forwarding");
    for (int i = 0; i < 16; i++) begin
      forwardCase(i[3], i[2], i[1], i[0]);
    end
    finishTest();

    startTest("loadUse");
    loadUseCase(1'b1, 4'd3, 1'b1);
    loadUseCase(1'b0, 4'd3, 1'b0); // Replay after the stall
    loadUseCase(1'b1, 4'd4, 1'b1);
    loadUseCase(1'b0, 4'd4, 1'b0);
    loadUseCase(1'b1, 4'd7, 1'b0);
    finishTest();

    startTest("idle");
    idleCycle();
    noopWord(32'hEA00_0010); // Branch class
    idleCycle();
    noopWord(32'hE110_0002); // TST has no ALU mapping
    idleCycle();
    finishTest();

    $display("Tests run %0d, tests failed %0d, checks failed %0d",
             testCount, testFails, errorCount);
    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/decodeStage.sv ====
// Decode stage only; later stages drive the ex/mem/wb ports, upstream must replay on stall
`timescale 1ns/10ps

module decodeStage import decodePkg::*; (
  input logic Clk,
  input logic reset,
  input logic [dataWidth-1:0] instr,
  input logic instrValid,
  input logic [regAddrWidth-1:0] exRd,
  input logic exRfEnable,
  input logic exLoad,
  input logic [dataWidth-1:0] exResult,
  input logic [regAddrWidth-1:0] memRd,
  input logic memRfEnable,
  input logic [dataWidth-1:0] memResult,
  input logic [regAddrWidth-1:0] wbRd,
  input logic wbWrite,
  input logic [dataWidth-1:0] wbData,
  output logic stall,
  output logic issueValid,
  output aluOpT issueAluOp,
  output addrModeT issueAddrMode,
  output logic issueSetFlags,
  output logic issueLoad,
  output logic issueRfEnable,
  output logic issueMemSize,
  output logic issueMemWrite,
  output logic issueMemEnable,
  output logic [dataWidth-1:0] issueOpA,
  output logic [dataWidth-1:0] issueOpB,
  output logic [dataWidth-1:0] issueOpD,
  output logic [regAddrWidth-1:0] issueRd,
  output logic [offsetWidth-1:0] issueImm12
);

  instrWordT instrWord;
  fwdSelT fwdSelA;
  fwdSelT fwdSelB;
  logic [dataWidth-1:0] rawA;
  logic [dataWidth-1:0] rawB;
  logic [dataWidth-1:0] rawD;

  decodeCtrlIf ctrlBus ();

  assign instrWord = instr;

  controlDecoder u_controlDecoder (
    .instr (instrWord),
    .ctrl  (ctrlBus.source)
  );

  hazardUnit u_hazardUnit (
    .instr       (instrWord),
    .instrValid  (instrValid),
    .exRd        (exRd),
    .exRfEnable  (exRfEnable),
    .exLoad      (exLoad),
    .memRd       (memRd),
    .memRfEnable (memRfEnable),
    .wbRd        (wbRd),
    .wbWrite     (wbWrite),
    .fwdSelA     (fwdSelA),
    .fwdSelB     (fwdSelB),
    .stall       (stall)
  );

  registerFile u_registerFile (
    .Clk      (Clk),
    .rdAddrA  (instrWord.dataProc.rn),
    .rdAddrB  (instrWord.dataProc.operand2[regAddrWidth-1:0]), // Rm
    .rdAddrD  (instrWord.dataProc.rd),
    .wrAddr   (wbRd),
    .wrEnable (wbWrite),
    .wrData   (wbData),
    .rdDataA  (rawA),
    .rdDataB  (rawB),
    .rdDataD  (rawD)
  );

  issueRegister u_issueRegister (
    .Clk            (Clk),
    .reset          (reset),
    .ctrl           (ctrlBus.sink),
    .instr          (instrWord),
    .instrValid     (instrValid),
    .stall          (stall),
    .fwdSelA        (fwdSelA),
    .fwdSelB        (fwdSelB),
    .rawA           (rawA),
    .rawB           (rawB),
    .rawD           (rawD),
    .exResult       (exResult),
    .memResult      (memResult),
    .wbData         (wbData),
    .issueValid     (issueValid),
    .issueAluOp     (issueAluOp),
    .issueAddrMode  (issueAddrMode),
    .issueSetFlags  (issueSetFlags),
    .issueLoad      (issueLoad),
    .issueRfEnable  (issueRfEnable),
    .issueMemSize   (issueMemSize),
    .issueMemWrite  (issueMemWrite),
    .issueMemEnable (issueMemEnable),
    .issueOpA       (issueOpA),
    .issueOpB       (issueOpB),
    .issueOpD       (issueOpD),
    .issueRd        (issueRd),
    .issueImm12     (issueImm12)
  );

endmodule

// ==== verilog/issueRegister.sv ====
// One ID/EX slot, no hold; a stall or idle cycle issues a bubble, operand B is Rm unforwarded
`timescale 1ns/10ps

module issueRegister import decodePkg::*; (
  input logic Clk,
  input logic reset,
  decodeCtrlIf.sink ctrl,
  input instrWordT instr,
  input logic instrValid,
  input logic stall,
  input fwdSelT fwdSelA,
  input fwdSelT fwdSelB,
  input logic [dataWidth-1:0] rawA,
  input logic [dataWidth-1:0] rawB,
  input logic [dataWidth-1:0] rawD,
  input logic [dataWidth-1:0] exResult,
  input logic [dataWidth-1:0] memResult,
  input logic [dataWidth-1:0] wbData,
  output logic issueValid,
  output aluOpT issueAluOp,
  output addrModeT issueAddrMode,
  output logic issueSetFlags,
  output logic issueLoad,
  output logic issueRfEnable,
  output logic issueMemSize,
  output logic issueMemWrite,
  output logic issueMemEnable,
  output logic [dataWidth-1:0] issueOpA,
  output logic [dataWidth-1:0] issueOpB,
  output logic [dataWidth-1:0] issueOpD,
  output logic [regAddrWidth-1:0] issueRd,
  output logic [offsetWidth-1:0] issueImm12
);

  logic issueNow;

  function automatic logic [dataWidth-1:0] selectOperand(input fwdSelT sel,
                                                         input logic [dataWidth-1:0] raw);
    logic [dataWidth-1:0] value;
    case (sel)
      fwdEx: value = exResult;
      fwdMem: value = memResult;
      fwdWb: value = wbData; // Write port of this same cycle
      default: value = raw;
    endcase
    return value;
  endfunction

  assign issueNow = instrValid && !stall;

  always_ff @(posedge Clk) begin
    if (reset || !issueNow) begin
      issueValid <= 1'b0;
      issueAluOp <= opPassA;
      issueAddrMode <= amReg;
      issueSetFlags <= 1'b0;
      issueLoad <= 1'b0;
      issueRfEnable <= 1'b0;
      issueMemSize <= 1'b0;
      issueMemWrite <= 1'b0;
      issueMemEnable <= 1'b0;
    end else begin
      issueValid <= 1'b1;
      issueAluOp <= ctrl.aluOp;
      issueAddrMode <= ctrl.addrMode;
      issueSetFlags <= ctrl.setFlags;
      issueLoad <= ctrl.loadInstr;
      issueRfEnable <= ctrl.rfEnable;
      issueMemSize <= ctrl.memSize;
      issueMemWrite <= ctrl.memWrite;
      issueMemEnable <= ctrl.memEnable;
    end
  end

  always_ff @(posedge Clk) begin
    issueOpA <= selectOperand(fwdSelA, rawA);
    issueOpB <= rawB;
    issueOpD <= selectOperand(fwdSelB, rawD);
    issueRd <= instr.dataProc.rd;
    issueImm12 <= instr.dataProc.operand2;
  end

  assert property (@(posedge Clk) disable iff (reset) !(issueMemWrite && issueLoad));

endmodule

// ==== verilog/registerFile.sv ====
// No reset, contents are undefined until written; reads are combinational and see old data
`timescale 1ns/10ps

module registerFile import decodePkg::*; (
  input logic Clk,
  input logic [regAddrWidth-1:0] rdAddrA,
  input logic [regAddrWidth-1:0] rdAddrB,
  input logic [regAddrWidth-1:0] rdAddrD,
  input logic [regAddrWidth-1:0] wrAddr,
  input logic wrEnable,
  input logic [dataWidth-1:0] wrData,
  output logic [dataWidth-1:0] rdDataA,
  output logic [dataWidth-1:0] rdDataB,
  output logic [dataWidth-1:0] rdDataD
);

  logic [dataWidth-1:0] regs [regCount];
  logic [regCount-1:0] wrSel;

  // One-hot load enable per register
  always_comb begin
    wrSel = '0;
    if (wrEnable) begin
      wrSel[wrAddr] = 1'b1;
    end
  end

  for (genvar i = 0; i < regCount; i++) begin : genRegs
    always_ff @(posedge Clk) begin
      if (wrSel[i]) begin
        regs[i] <= wrData;
      end
    end
  end

  assign rdDataA = regs[rdAddrA];
  assign rdDataB = regs[rdAddrB];
  assign rdDataD = regs[rdAddrD];

endmodule

// ==== verilog/hazardUnit.sv ====
// Forwards rn into operand A and rd into operand D; the Rm operand is never forwarded
`timescale 1ns/10ps

module hazardUnit import decodePkg::*; (
  input instrWordT instr,
  input logic instrValid,
  input logic [regAddrWidth-1:0] exRd,
  input logic exRfEnable,
  input logic exLoad,
  input logic [regAddrWidth-1:0] memRd,
  input logic memRfEnable,
  input logic [regAddrWidth-1:0] wbRd,
  input logic wbWrite,
  output fwdSelT fwdSelA,
  output fwdSelT fwdSelB,
  output logic stall
);

  logic [regAddrWidth-1:0] srcA;
  logic [regAddrWidth-1:0] srcB;

  // Youngest producer wins
  function automatic fwdSelT pickSource(input logic [regAddrWidth-1:0] src);
    fwdSelT sel;
    if (exRfEnable && (exRd == src)) begin
      sel = fwdEx;
    end else if (memRfEnable && (memRd == src)) begin
      sel = fwdMem;
    end else if (wbWrite && (wbRd == src)) begin
      sel = fwdWb;
    end else begin
      sel = fwdNone;
    end
    return sel;
  endfunction

  assign srcA = instr.dataProc.rn;
  assign srcB = instr.dataProc.rd; // Same bits in the load/store view

  always_comb begin
    fwdSelA = pickSource(srcA);
    fwdSelB = pickSource(srcB);
  end

  // Load result not ready until MEM, hold the instruction one cycle
  assign stall = instrValid && exLoad && ((exRd == srcA) || (exRd == srcB));

endmodule

// ==== verilog/controlDecoder.sv ====
// Purely combinational; condition field is ignored and compare opcodes decode as no-op
`timescale 1ns/10ps

module controlDecoder import decodePkg::*; (
  input instrWordT instr,
  decodeCtrlIf.source ctrl
);

  aluOpT dpAluOp;
  logic dpDefined;

  // Opcode field to ALU code
  always_comb begin
    dpDefined = 1'b1;
    case (instr.dataProc.opcode)
      dpAnd: dpAluOp = opAnd;
      dpEor: dpAluOp = opEor;
      dpSub: dpAluOp = opSub;
      dpRsb: dpAluOp = opRsb;
      dpAdd: dpAluOp = opAdd;
      dpAdc: dpAluOp = opAdc;
      dpSbc: dpAluOp = opSbc;
      dpRsc: dpAluOp = opRsc;
      dpOrr: dpAluOp = opOrr;
      dpMov: dpAluOp = opMov;
      dpBic: dpAluOp = opBic;
      dpMvn: dpAluOp = opMvn;
      default: begin
        dpAluOp = opPassA;
        dpDefined = 1'b0; // TST, TEQ, CMP, CMN
      end
    endcase
  end

  always_comb begin
    ctrl.aluOp = opPassA;
    ctrl.addrMode = amReg;
    ctrl.setFlags = 1'b0;
    ctrl.loadInstr = 1'b0;
    ctrl.rfEnable = 1'b0;
    ctrl.memSize = 1'b0;
    ctrl.memWrite = 1'b0;
    ctrl.memEnable = 1'b0;

    case (instr.dataProc.instrClass)
      clsDpShift, clsDpImm: begin
        if (dpDefined) begin
          ctrl.aluOp = dpAluOp;
          ctrl.addrMode = (instr.dataProc.instrClass == clsDpImm) ? amRotImm : amShiftReg;
          ctrl.setFlags = instr.dataProc.sBit;
          ctrl.rfEnable = 1'b1;
        end
      end

      clsLsImm, clsLsReg: begin
        // Address is rn plus or minus the offset
        ctrl.aluOp = instr.loadStore.uBit ? opAdd : opSub;
        ctrl.addrMode = (instr.loadStore.instrClass == clsLsImm) ? amImm12 : amShiftReg;
        ctrl.loadInstr = instr.loadStore.lBit;
        ctrl.memWrite = ~instr.loadStore.lBit;
        ctrl.memSize = instr.loadStore.bBit;
        ctrl.memEnable = 1'b1;
        ctrl.rfEnable = 1'b1;
      end

      default: begin
        // Branches and unused classes keep the no-op bundle
        ctrl.aluOp = opPassA;
      end
    endcase
  end

endmodule

// ==== verilog/decodeCtrlIf.sv ====
// Control bundle of one decoded instruction; no handshake, valid travels separately
`timescale 1ns/10ps

interface decodeCtrlIf import decodePkg::*; ();

  aluOpT aluOp;
  addrModeT addrMode;
  logic setFlags;
  logic loadInstr;
  logic rfEnable;
  logic memSize; // Byte when high
  logic memWrite;
  logic memEnable;

  modport source (
    output aluOp, addrMode, setFlags, loadInstr,
    output rfEnable, memSize, memWrite, memEnable
  );

  modport sink (
    input aluOp, addrMode, setFlags, loadInstr,
    input rfEnable, memSize, memWrite, memEnable
  );

endinterface

// ==== verilog/decodePkg.sv ====
// Encodings follow the ARM-style core; branch and other unlisted classes decode as no-op
package decodePkg;

  localparam int dataWidth = 32;
  localparam int regAddrWidth = 4;
  localparam int regCount = 2 ** regAddrWidth;
  localparam int offsetWidth = 12; // Low field of both instruction views

  // ALU encoding of the execute stage
  typedef enum logic [3:0] {
    opAdd   = 4'b0000,
    opAdc   = 4'b0001,
    opSub   = 4'b0010,
    opSbc   = 4'b0011,
    opRsb   = 4'b0100,
    opRsc   = 4'b0101,
    opAnd   = 4'b0110,
    opOrr   = 4'b0111,
    opEor   = 4'b1000,
    opPassA = 4'b1001, // Also the no-op code
    opMov   = 4'b1010,
    opMvn   = 4'b1011,
    opBic   = 4'b1100
  } aluOpT;

  // Data-processing opcodes as encoded in bits 24:21
  localparam logic [3:0] dpAnd = 4'b0000;
  localparam logic [3:0] dpEor = 4'b0001;
  localparam logic [3:0] dpSub = 4'b0010;
  localparam logic [3:0] dpRsb = 4'b0011;
  localparam logic [3:0] dpAdd = 4'b0100;
  localparam logic [3:0] dpAdc = 4'b0101;
  localparam logic [3:0] dpSbc = 4'b0110;
  localparam logic [3:0] dpRsc = 4'b0111;
  localparam logic [3:0] dpOrr = 4'b1100;
  localparam logic [3:0] dpMov = 4'b1101;
  localparam logic [3:0] dpBic = 4'b1110;
  localparam logic [3:0] dpMvn = 4'b1111;

  typedef enum logic [1:0] {
    amRotImm   = 2'b00,
    amReg      = 2'b01,
    amImm12    = 2'b10,
    amShiftReg = 2'b11
  } addrModeT;

  typedef enum logic [1:0] {
    fwdNone = 2'b00, // Register file
    fwdWb   = 2'b01,
    fwdEx   = 2'b10,
    fwdMem  = 2'b11
  } fwdSelT;

  typedef enum logic [2:0] {
    clsDpShift = 3'b000,
    clsDpImm   = 3'b001,
    clsLsImm   = 3'b010,
    clsLsReg   = 3'b011
  } instrClassT;

  typedef struct packed {
    logic [3:0] cond;
    instrClassT instrClass;
    logic [3:0] opcode;
    logic sBit;
    logic [regAddrWidth-1:0] rn;
    logic [regAddrWidth-1:0] rd;
    logic [offsetWidth-1:0] operand2;
  } dataProcT;

  typedef struct packed {
    logic [3:0] cond;
    instrClassT instrClass;
    logic pBit;
    logic uBit; // Add offset when set
    logic bBit; // Byte access
    logic wBit;
    logic lBit; // Load when set
    logic [regAddrWidth-1:0] rn;
    logic [regAddrWidth-1:0] rd;
    logic [offsetWidth-1:0] offset12;
  } loadStoreT;

  typedef union packed {
    dataProcT dataProc;
    loadStoreT loadStore;
  } instrWordT;

endpackage
